// ==== Bender.yml ====
package:
  name: video_adjust

sources:
  - common/vproc_pkg.sv
  - saturation/luma_sum.sv
  - saturation/chroma_mix.sv
  - saturation/saturation.sv
  - rtl/coef_regs.sv
  - rtl/video_adjust_top.sv
  - target: test
    files:
      - verif/video_adjust_properties.sv
      - verif/tb_video_adjust.sv

// ==== common/vproc_pkg.sv ====
// Video processing shared definitions

package vproc_pkg;

    // ------------------------------------------------------------------
    // pixel and coefficient formats
    // ------------------------------------------------------------------
    localparam int PIXEL_WIDTH    = 8;
    // Q3.6 unsigned, 64 is 1.0
    localparam int COE_WIDTH      = 9;
    localparam int COE_FRAC_WIDTH = 6;

    // half an output lsb, added before the shift
    localparam int ROUND_ADD      = 1 << (COE_FRAC_WIDTH - 1);
    localparam int PIX_MAX        = (1 << PIXEL_WIDTH) - 1;

    // ------------------------------------------------------------------
    // register map
    // ------------------------------------------------------------------
    localparam int CFG_ADDR_WIDTH = 2;

    localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_YCOE0 = 2'd0;
    localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_YCOE1 = 2'd1;
    localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_YCOE2 = 2'd2;
    localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_SAT   = 2'd3;

    // luma weights near 0.299, 0.587, 0.114
    localparam logic [COE_WIDTH-1:0] YCOE0_DEFAULT = 9'd19;
    localparam logic [COE_WIDTH-1:0] YCOE1_DEFAULT = 9'd38;
    localparam logic [COE_WIDTH-1:0] YCOE2_DEFAULT = 9'd7;
    // unity saturation
    localparam logic [COE_WIDTH-1:0] SAT_DEFAULT   = 9'd64;

    // ------------------------------------------------------------------
    // pipeline timing
    // ------------------------------------------------------------------
    // luma input register to luma out
    localparam int LUMA_LATENCY = 4;
    // sampled input to video out
    localparam int PIPE_LATENCY = 9;

endpackage

// ==== rtl/coef_regs.sv ====
// Coefficient registers
`timescale 1ns/1ps

module coef_regs import vproc_pkg::*; (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      cfg_req_i,
    input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr_i,
    input  logic [COE_WIDTH-1:0]      cfg_data_i,
    output logic                      cfg_ack_o,
    output logic [COE_WIDTH-1:0]      ycoe0_o,
    output logic [COE_WIDTH-1:0]      ycoe1_o,
    output logic [COE_WIDTH-1:0]      ycoe2_o,
    output logic [COE_WIDTH-1:0]      sat_o
);

    logic                 ack_q;
    logic [COE_WIDTH-1:0] ycoe0_q;
    logic [COE_WIDTH-1:0] ycoe1_q;
    logic [COE_WIDTH-1:0] ycoe2_q;
    logic [COE_WIDTH-1:0] sat_q;

    // write once per request while ack is low
    logic wr_en;

    assign wr_en = cfg_req_i && !ack_q;

    // ------------------------------------------------------------------
    // four-phase handshake
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else if (wr_en) begin
            ack_q <= 1'b1;
        end else if (!cfg_req_i) begin
            // host has released req
            ack_q <= 1'b0;
        end
    end

    // ------------------------------------------------------------------
    // register file
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ycoe0_q <= YCOE0_DEFAULT;
            ycoe1_q <= YCOE1_DEFAULT;
            ycoe2_q <= YCOE2_DEFAULT;
            sat_q   <= SAT_DEFAULT;
        end else if (wr_en) begin
            case (cfg_addr_i)
                ADDR_YCOE0: ycoe0_q <= cfg_data_i;
                ADDR_YCOE1: ycoe1_q <= cfg_data_i;
                ADDR_YCOE2: ycoe2_q <= cfg_data_i;
                ADDR_SAT:   sat_q   <= cfg_data_i;
            endcase
        end
    end

    assign cfg_ack_o = ack_q;
    assign ycoe0_o   = ycoe0_q;
    assign ycoe1_o   = ycoe1_q;
    assign ycoe2_o   = ycoe2_q;
    assign sat_o     = sat_q;

endmodule

// ==== rtl/video_adjust_top.sv ====
// Video colour adjustment top
`timescale 1ns/1ps

module video_adjust_top import vproc_pkg::*; (
    input  logic                      clk,
    input  logic                      reset_i,
    // register port
    input  logic                      cfg_req_i,
    input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr_i,
    input  logic [COE_WIDTH-1:0]      cfg_data_i,
    output logic                      cfg_ack_o,
    // video in
    input  logic [3*PIXEL_WIDTH-1:0]  di_i,
    input  logic                      de_i,
    input  logic                      hs_i,
    input  logic                      vs_i,
    // video out
    output logic [3*PIXEL_WIDTH-1:0]  do_o,
    output logic                      de_o,
    output logic                      hs_o,
    output logic                      vs_o
);

    logic [COE_WIDTH-1:0] ycoe0;
    logic [COE_WIDTH-1:0] ycoe1;
    logic [COE_WIDTH-1:0] ycoe2;
    logic [COE_WIDTH-1:0] sat;

    coef_regs u_coef_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .cfg_req_i  (cfg_req_i),
        .cfg_addr_i (cfg_addr_i),
        .cfg_data_i (cfg_data_i),
        .cfg_ack_o  (cfg_ack_o),
        .ycoe0_o    (ycoe0),
        .ycoe1_o    (ycoe1),
        .ycoe2_o    (ycoe2),
        .sat_o      (sat)
    );

    saturation u_saturation (
        .clk     (clk),
        .reset_i (reset_i),
        .di_i    (di_i),
        .de_i    (de_i),
        .hs_i    (hs_i),
        .vs_i    (vs_i),
        .ycoe0_i (ycoe0),
        .ycoe1_i (ycoe1),
        .ycoe2_i (ycoe2),
        .sat_i   (sat),
        .do_o    (do_o),
        .de_o    (de_o),
        .hs_o    (hs_o),
        .vs_o    (vs_o)
    );

endmodule

// ==== saturation/chroma_mix.sv ====
// Chroma mix for one channel
`timescale 1ns/1ps

module chroma_mix import vproc_pkg::*; (
    input  logic                   clk,
    input  logic [PIXEL_WIDTH-1:0] p_i,
    input  logic [PIXEL_WIDTH-1:0] y_i,
    input  logic [COE_WIDTH-1:0]   sat_i,
    output logic [PIXEL_WIDTH-1:0] p_o
);

    // p - y needs one extra bit for the sign
    localparam int DIFF_W = PIXEL_WIDTH + 1;
    // signed difference times zero-extended saturation
    localparam int PROD_W = DIFF_W + COE_WIDTH + 1;
    localparam int YS_W   = PIXEL_WIDTH + COE_FRAC_WIDTH;
    localparam int MIX_W  = PROD_W + 1;

    localparam logic signed [MIX_W-1:0] ROUND_C = MIX_W'(ROUND_ADD);

    logic signed [DIFF_W-1:0] diff_q;
    logic        [YS_W-1:0]   y_scaled_q;
    logic        [YS_W-1:0]   y_scaled_d;
    logic signed [PROD_W-1:0] prod_q;
    logic signed [MIX_W-1:0]  mix_q;

    // floor division by 64
    logic signed [MIX_W-1:0]  mix_sh;

    assign mix_sh = mix_q >>> COE_FRAC_WIDTH;

    // ------------------------------------------------------------------
    // stages 1 to 4
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        // stage 1
        diff_q     <= $signed({1'b0, p_i}) - $signed({1'b0, y_i});
        y_scaled_q <= {y_i, {COE_FRAC_WIDTH{1'b0}}};

        // stage 2
        prod_q     <= diff_q * $signed({1'b0, sat_i});
        y_scaled_d <= y_scaled_q;

        // stage 3
        mix_q <= prod_q + $signed({1'b0, y_scaled_d}) + ROUND_C;

        // stage 4, clamp to 0..255
        if (mix_sh < 0) begin
            p_o <= '0;
        end else if (mix_sh > PIX_MAX) begin
            p_o <= PIXEL_WIDTH'(PIX_MAX);
        end else begin
            p_o <= mix_sh[PIXEL_WIDTH-1:0];
        end
    end

endmodule

// ==== saturation/luma_sum.sv ====
// Weighted luma sum
`timescale 1ns/1ps

module luma_sum import vproc_pkg::*; (
    input  logic                   clk,
    input  logic [PIXEL_WIDTH-1:0] r_i,
    input  logic [PIXEL_WIDTH-1:0] g_i,
    input  logic [PIXEL_WIDTH-1:0] b_i,
    input  logic [COE_WIDTH-1:0]   ycoe0_i,
    input  logic [COE_WIDTH-1:0]   ycoe1_i,
    input  logic [COE_WIDTH-1:0]   ycoe2_i,
    output logic [PIXEL_WIDTH-1:0] y_o
);

    // full width product, then one carry bit per addition
    localparam int PROD_W = PIXEL_WIDTH + COE_WIDTH;
    localparam int RG_W   = PROD_W + 1;
    localparam int SUM_W  = PROD_W + 2;

    localparam logic [SUM_W-1:0] ROUND_C = SUM_W'(ROUND_ADD);

    logic [PROD_W-1:0] prod_r_q;
    logic [PROD_W-1:0] prod_g_q;
    logic [PROD_W-1:0] prod_b_q;
    logic [PROD_W-1:0] prod_b_d;
    logic [RG_W-1:0]   sum_rg_q;
    logic [SUM_W-1:0]  sum_q;

    // integer part of the rounded sum
    logic [SUM_W-COE_FRAC_WIDTH-1:0] y_int;

    assign y_int = sum_q[SUM_W-1:COE_FRAC_WIDTH];

    // ------------------------------------------------------------------
    // stages 1 to 4
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        // stage 1
        prod_r_q <= r_i * ycoe0_i;
        prod_g_q <= g_i * ycoe1_i;
        prod_b_q <= b_i * ycoe2_i;

        // stage 2, blue waits a cycle
        sum_rg_q <= prod_r_q + prod_g_q;
        prod_b_d <= prod_b_q;

        // stage 3
        sum_q <= sum_rg_q + prod_b_d + ROUND_C;

        // stage 4
        if (y_int > PIX_MAX) begin
            y_o <= PIXEL_WIDTH'(PIX_MAX);
        end else begin
            y_o <= sum_q[COE_FRAC_WIDTH +: PIXEL_WIDTH];
        end
    end

endmodule

// ==== saturation/saturation.sv ====
// Saturation pipeline
`timescale 1ns/1ps

module saturation import vproc_pkg::*; (
    input  logic                     clk,
    input  logic                     reset_i,
    // red low, green middle, blue high
    input  logic [3*PIXEL_WIDTH-1:0] di_i,
    input  logic                     de_i,
    input  logic                     hs_i,
    input  logic                     vs_i,
    input  logic [COE_WIDTH-1:0]     ycoe0_i,
    input  logic [COE_WIDTH-1:0]     ycoe1_i,
    input  logic [COE_WIDTH-1:0]     ycoe2_i,
    input  logic [COE_WIDTH-1:0]     sat_i,
    output logic [3*PIXEL_WIDTH-1:0] do_o,
    output logic                     de_o,
    output logic                     hs_o,
    output logic                     vs_o
);

    logic [3*PIXEL_WIDTH-1:0] pix_q;
    logic [3*PIXEL_WIDTH-1:0] pix_dly [LUMA_LATENCY];
    logic [PIXEL_WIDTH-1:0]   luma;
    logic [PIPE_LATENCY-1:0]  de_sr;
    logic [PIPE_LATENCY-1:0]  hs_sr;
    logic [PIPE_LATENCY-1:0]  vs_sr;

    // input register and pixel delay to meet luma
    always_ff @(posedge clk) begin
        pix_q      <= di_i;
        pix_dly[0] <= pix_q;
        for (int i = 1; i < LUMA_LATENCY; i++) begin
            pix_dly[i] <= pix_dly[i-1];
        end
    end

    // sync delay line, matches the full pixel path
    always_ff @(posedge clk) begin
        if (reset_i) begin
            de_sr <= '0;
            hs_sr <= '0;
            vs_sr <= '0;
        end else begin
            de_sr <= {de_sr[PIPE_LATENCY-2:0], de_i};
            hs_sr <= {hs_sr[PIPE_LATENCY-2:0], hs_i};
            vs_sr <= {vs_sr[PIPE_LATENCY-2:0], vs_i};
        end
    end

    assign de_o = de_sr[PIPE_LATENCY-1];
    assign hs_o = hs_sr[PIPE_LATENCY-1];
    assign vs_o = vs_sr[PIPE_LATENCY-1];

    luma_sum u_luma_sum (
        .clk     (clk),
        .r_i     (pix_q[0*PIXEL_WIDTH +: PIXEL_WIDTH]),
        .g_i     (pix_q[1*PIXEL_WIDTH +: PIXEL_WIDTH]),
        .b_i     (pix_q[2*PIXEL_WIDTH +: PIXEL_WIDTH]),
        .ycoe0_i (ycoe0_i),
        .ycoe1_i (ycoe1_i),
        .ycoe2_i (ycoe2_i),
        .y_o     (luma)
    );

    for (genvar ch = 0; ch < 3; ch++) begin : g_mix
        chroma_mix u_chroma_mix (
            .clk   (clk),
            .p_i   (pix_dly[LUMA_LATENCY-1][ch*PIXEL_WIDTH +: PIXEL_WIDTH]),
            .y_i   (luma),
            .sat_i (sat_i),
            .p_o   (do_o[ch*PIXEL_WIDTH +: PIXEL_WIDTH])
        );
    end

endmodule

// ==== sim.f ====
common/vproc_pkg.sv
saturation/luma_sum.sv
saturation/chroma_mix.sv
saturation/saturation.sv
rtl/coef_regs.sv
rtl/video_adjust_top.sv
verif/video_adjust_properties.sv
verif/tb_video_adjust.sv

// ==== verif/tb_video_adjust.sv ====
// Video adjust testbench
`timescale 1ns/1ps

module tb_video_adjust import vproc_pkg::*; ();

    localparam int ACK_TIMEOUT   = 50;
    localparam int DRAIN_TIMEOUT = 200;

    logic                      clk;
    logic                      reset_i;
    logic                      cfg_req_i;
    logic [CFG_ADDR_WIDTH-1:0] cfg_addr_i;
    logic [COE_WIDTH-1:0]      cfg_data_i;
    logic                      cfg_ack_o;
    logic [3*PIXEL_WIDTH-1:0]  di_i;
    logic                      de_i;
    logic                      hs_i;
    logic                      vs_i;
    logic [3*PIXEL_WIDTH-1:0]  do_o;
    logic                      de_o;
    logic                      hs_o;
    logic                      vs_o;

    // expected output of the pixel currently driven
    logic [3*PIXEL_WIDTH-1:0]  cur_exp;
    string                     cur_name;
    // set while a pixel line from the data file is driven
    logic                      cur_line;

    int   edge_count  = 0;
    logic reset_seen  = 1'b0;
    int   pix_total   = 0;
    int   pix_checked = 0;

    // one entry per sampled edge due PIPE_LATENCY edges later
    int                       due_q[$];
    logic [2:0]               sync_q[$];
    logic [3*PIXEL_WIDTH-1:0] exp_q[$];
    logic                     chk_q[$];
    logic                     line_q[$];
    string                    name_q[$];

    video_adjust_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic end_with_failure();
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
            end_with_failure();
        end
    endtask

    function automatic int count_assertion_failures();
        return DUT.u_coef_regs.u_handshake_props.fail_count +
               DUT.u_saturation.u_sync_props.fail_count;
    endfunction

    // ------------------------------------------------------------------
    // expectation tracking
    // ------------------------------------------------------------------
    always @(posedge clk) begin
        due_q.push_back(edge_count + PIPE_LATENCY);
        // sync line is cleared on a reset edge
        sync_q.push_back(reset_i ? 3'b000 : {vs_i, hs_i, de_i});
        exp_q.push_back(cur_exp);
        chk_q.push_back(!reset_i && de_i);
        line_q.push_back(!reset_i && cur_line);
        name_q.push_back(cur_name);
        reset_seen = reset_i;
        edge_count = edge_count + 1;
    end

    task automatic compare_front();
        string                    name;
        logic [2:0]               sync_exp;
        logic [3*PIXEL_WIDTH-1:0] pix_exp;
        logic                     chk;
        logic                     line;
        void'(due_q.pop_front());
        name     = name_q.pop_front();
        sync_exp = sync_q.pop_front();
        pix_exp  = exp_q.pop_front();
        chk      = chk_q.pop_front();
        line     = line_q.pop_front();
        check_value({name, " de_o"}, sync_exp[0], de_o);
        check_value({name, " hs_o"}, sync_exp[1], hs_o);
        check_value({name, " vs_o"}, sync_exp[2], vs_o);
        if (chk) begin
            check_value({name, " red"}, pix_exp[0 +: PIXEL_WIDTH], do_o[0 +: PIXEL_WIDTH]);
            check_value({name, " green"}, pix_exp[PIXEL_WIDTH +: PIXEL_WIDTH],
                        do_o[PIXEL_WIDTH +: PIXEL_WIDTH]);
            check_value({name, " blue"}, pix_exp[2*PIXEL_WIDTH +: PIXEL_WIDTH],
                        do_o[2*PIXEL_WIDTH +: PIXEL_WIDTH]);
        end
        if (line) begin
            pix_checked++;
        end
    endtask

    always @(negedge clk) begin
        if (count_assertion_failures() != 0) begin
            $display("a bound assertion on the handshake or sync timing failed");
            end_with_failure();
        end
        if (edge_count > 0 && reset_seen) begin
            check_value("reset de_o", 0, de_o);
            check_value("reset hs_o", 0, hs_o);
            check_value("reset vs_o", 0, vs_o);
            check_value("reset cfg_ack_o", 0, cfg_ack_o);
        end
        if (due_q.size() > 0 && due_q[0] == edge_count) begin
            compare_front();
        end
    end

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    task automatic drive_idle();
        @(negedge clk);
        di_i     = '0;
        de_i     = 1'b0;
        hs_i     = 1'b0;
        vs_i     = 1'b0;
        cur_exp  = '0;
        cur_name = "idle";
        cur_line = 1'b0;
    endtask

    task automatic drive_pixel(input string name, input int r, input int g, input int b,
                               input int de, input int hs, input int vs,
                               input int er, input int eg, input int eb);
        @(negedge clk);
        di_i     = {b[7:0], g[7:0], r[7:0]};
        de_i     = de[0];
        hs_i     = hs[0];
        vs_i     = vs[0];
        cur_exp  = {eb[7:0], eg[7:0], er[7:0]};
        cur_name = name;
        cur_line = 1'b1;
    endtask

    task automatic write_reg(input int addr, input int data);
        int wait_cnt;
        // blanking long enough to empty the pipeline
        repeat (PIPE_LATENCY + 1) drive_idle();
        repeat ($urandom_range(0, 3)) drive_idle();
        cfg_addr_i = addr[CFG_ADDR_WIDTH-1:0];
        cfg_data_i = data[COE_WIDTH-1:0];
        cfg_req_i  = 1'b1;
        wait_cnt   = 0;
        while (cfg_ack_o !== 1'b1) begin
            drive_idle();
            wait_cnt++;
            if (wait_cnt > ACK_TIMEOUT) begin
                $display("write to register %0d was never acknowledged", addr);
                end_with_failure();
            end
        end
        cfg_req_i = 1'b0;
        wait_cnt  = 0;
        while (cfg_ack_o !== 1'b0) begin
            drive_idle();
            wait_cnt++;
            if (wait_cnt > ACK_TIMEOUT) begin
                $display("ack stayed high after req was released, register %0d", addr);
                end_with_failure();
            end
        end
    endtask

    initial begin
        int    fd;
        int    code;
        int    seed;
        int    addr;
        int    data;
        int    wait_cnt;
        int    f[9];
        string kind;
        string name;
        string rest;
        seed       = $urandom(32'h1532_9315);
        // sync held high during reset to show the outputs stay low
        reset_i    = 1'b1;
        cfg_req_i  = 1'b0;
        cfg_addr_i = '0;
        cfg_data_i = '0;
        di_i       = '0;
        de_i       = 1'b1;
        hs_i       = 1'b1;
        vs_i       = 1'b1;
        cur_exp    = '0;
        cur_name   = "reset";
        cur_line   = 1'b0;
        repeat (16) @(negedge clk);
        reset_i = 1'b0;
        drive_idle();

        fd = $fopen("verif/video_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            end_with_failure();
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                code = $fgets(rest, fd);
            end else if (kind == "w") begin
                code = $fscanf(fd, "%d %d", addr, data);
                if (code != 2) begin
                    $display("malformed register write line in the test data");
                    end_with_failure();
                end
                write_reg(addr, data);
            end else if (kind == "p") begin
                code = $fscanf(fd, "%s %d %d %d %d %d %d %d %d %d", name,
                               f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                if (code != 10) begin
                    $display("malformed pixel line in the test data");
                    end_with_failure();
                end
                drive_pixel(name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                pix_total++;
                // random gaps in de
                repeat ($urandom_range(0, 2)) drive_idle();
            end else begin
                $display("unknown line kind %s in the test data", kind);
                end_with_failure();
            end
        end
        $fclose(fd);

        wait_cnt = 0;
        while (pix_checked < pix_total) begin
            drive_idle();
            wait_cnt++;
            if (wait_cnt > DRAIN_TIMEOUT) begin
                $display("only %0d of %0d pixels came out", pix_checked, pix_total);
                end_with_failure();
            end
        end
        repeat (2) drive_idle();
        if (count_assertion_failures() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("a bound assertion on the handshake or sync timing failed");
            end_with_failure();
        end
    end

endmodule

// ==== verif/video_adjust_properties.sv ====
// Video adjust assertions
`timescale 1ns/1ps

module video_adjust_properties import vproc_pkg::*; (
    input logic clk,
    input logic reset_i,
    input logic req_i,
    input logic ack_i,
    input logic de_in_i,
    input logic hs_in_i,
    input logic vs_in_i,
    input logic de_out_i,
    input logic hs_out_i,
    input logic vs_out_i
);

    // edges since reset up to the pipeline depth
    logic [3:0] settle_q;

    // assertion failures seen so far
    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            settle_q <= '0;
        end else if (settle_q != PIPE_LATENCY) begin
            settle_q <= settle_q + 4'd1;
        end
    end

    // ------------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------------
    ack_rise_needs_req: assert property (@(posedge clk) disable iff (reset_i)
        $rose(ack_i) |-> $past(req_i))
        else begin
            fail_count++;
            $error("ack rose while req was low");
        end

    ack_fall_needs_release: assert property (@(posedge clk) disable iff (reset_i)
        $fell(ack_i) |-> !$past(req_i))
        else begin
            fail_count++;
            $error("ack fell while req was still high");
        end

    // ------------------------------------------------------------------
    // sync latency
    // ------------------------------------------------------------------
    sync_latency: assert property (@(posedge clk) disable iff (reset_i)
        settle_q == PIPE_LATENCY |->
            {de_out_i, hs_out_i, vs_out_i} ==
            $past({de_in_i, hs_in_i, vs_in_i}, PIPE_LATENCY))
        else begin
            fail_count++;
            $error("sync outputs do not match the delayed inputs");
        end

endmodule

bind coef_regs video_adjust_properties u_handshake_props (
    .clk      (clk),
    .reset_i  (reset_i),
    .req_i    (cfg_req_i),
    .ack_i    (cfg_ack_o),
    .de_in_i  (1'b0),
    .hs_in_i  (1'b0),
    .vs_in_i  (1'b0),
    .de_out_i (1'b0),
    .hs_out_i (1'b0),
    .vs_out_i (1'b0)
);

bind saturation video_adjust_properties u_sync_props (
    .clk      (clk),
    .reset_i  (reset_i),
    .req_i    (1'b0),
    .ack_i    (1'b0),
    .de_in_i  (de_i),
    .hs_in_i  (hs_i),
    .vs_in_i  (vs_i),
    .de_out_i (de_o),
    .hs_out_i (hs_o),
    .vs_out_i (vs_o)
);

// ==== verif/video_testdata.txt ====
# w <addr> <value>   register write, decimal
# p <name> <r> <g> <b> <de> <hs> <vs> <exp_r> <exp_g> <exp_b>
p vsync 0 0 0 0 0 1 0 0 0
p hsync 0 0 0 0 1 0 0 0 0
p unity_a 10 200 30 1 0 0 10 200 30
p unity_b 255 0 128 1 0 0 255 0 128
p unity_c 0 0 0 1 0 0 0 0 0
p unity_d 255 255 255 1 0 0 255 255 255
p unity_e 17 99 240 1 0 0 17 99 240
w 3 0
p luma_a 10 200 30 1 0 0 125 125 125
p luma_b 255 255 255 1 0 0 255 255 255
p hsync_b 0 0 0 0 1 0 0 0 0
p luma_c 200 50 100 1 0 0 100 100 100
p luma_d 0 0 255 1 0 0 28 28 28
w 3 192
p sat_a 200 50 100 1 0 0 255 0 100
p sat_b 10 200 30 1 0 0 0 255 0
p sat_c 120 130 110 1 0 0 110 140 80
p sat_d 128 128 128 1 0 0 128 128 128
w 0 32
w 1 32
w 2 32
w 3 0
p wt_a 200 50 100 1 0 0 175 175 175
p wt_b 255 255 255 1 0 0 255 255 255
p wt_c 10 200 31 1 0 0 121 121 121
w 3 40
p mix_a 10 200 31 1 0 0 52 170 65
p mix_b 255 0 0 1 0 0 207 48 48
p blank 0 0 0 0 1 1 0 0 0
